// File: Bender.yml
package:
  name: lockstep

sources:
  # Package first, then leaf modules before the top level
  - verilog/lockstep_pkg.sv
  - verilog/lockstep_delay.sv
  - verilog/mini_core.sv
  - verilog/trace_checker.sv
  - verilog/lockstep_csr.sv
  - verilog/lockstep_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - testbench/lockstep_properties.sv
      - testbench/lockstep_tb.sv

// File: testbench/lockstep_properties.sv
// ************************************************
// Bound into lockstep_top, checks are off while rst_n is low
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module lockstep_properties (
  input logic clk,
  input logic rst_n,
  input logic s_bvalid,
  input logic s_bready,
  input logic s_rvalid,
  input logic s_rready,
  input logic clear_error,
  input logic corruption_detected
);

  int unsigned fail_count = 0;

  bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    s_bvalid && !s_bready |=> s_bvalid)
    else begin
      $error("bvalid dropped before bready");
      fail_count++;
    end

  rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    s_rvalid && !s_rready |=> s_rvalid)
    else begin
      $error("rvalid dropped before rready");
      fail_count++;
    end

  // Sticky flag only falls one cycle after a clear pulse
  flag_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(corruption_detected) |-> $past(clear_error))
    else begin
      $error("corruption_detected fell without clear_error");
      fail_count++;
    end

endmodule

bind lockstep_top lockstep_properties u_props (
  .clk, .rst_n, .s_bvalid, .s_bready, .s_rvalid, .s_rready,
  .clear_error, .corruption_detected
);

`default_nettype wire

// File: testbench/lockstep_tb.sv
// ************************************************
// Expects lockstep_top with LOCKSTEP_DELAY of 3 and sole access to its AXI4-Lite port
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module lockstep_tb;
  import lockstep_pkg::*;

  localparam int n_insn         = 200 + 1 + 5 + 50 + 4 + 20;
  localparam int timeout_cycles = n_insn * 40 + 200;

  logic                  clk;
  logic                  rst_n;
  logic [axi_addr_w-1:0] s_awaddr;
  logic                  s_awvalid;
  logic                  s_awready;
  logic [xlen-1:0]       s_wdata;
  logic [strb_w-1:0]     s_wstrb;
  logic                  s_wvalid;
  logic                  s_wready;
  axi_resp_e             s_bresp;
  logic                  s_bvalid;
  logic                  s_bready;
  logic [axi_addr_w-1:0] s_araddr;
  logic                  s_arvalid;
  logic                  s_arready;
  logic [xlen-1:0]       s_rdata;
  axi_resp_e             s_rresp;
  logic                  s_rvalid;
  logic                  s_rready;
  logic                  shadow_reset;
  logic                  corruption_detected;

  logic [31:0]     lfsr_state;
  logic [xlen-1:0] model_regs [nregs];

  lockstep_top #(.LOCKSTEP_DELAY(3)) dut0 (
    .clk, .rst_n,
    .s_awaddr, .s_awvalid, .s_awready,
    .s_wdata, .s_wstrb, .s_wvalid, .s_wready,
    .s_bresp, .s_bvalid, .s_bready,
    .s_araddr, .s_arvalid, .s_arready,
    .s_rdata, .s_rresp, .s_rvalid, .s_rready,
    .shadow_reset, .corruption_detected
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin : watchdog
    repeat (timeout_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the DUT stopped answering", timeout_cycles);
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

  initial begin : assertion_monitor
    wait (dut0.u_props.fail_count != 0);
    $display("A bound assertion on the DUT failed");
    $display("Simulation failed");
    $fatal(1, "assertion failed");
  end

  // Galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  task automatic take_random_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "check failed");
  endtask

  task automatic check_data(input string name, input logic [xlen-1:0] exp,
                            input logic [xlen-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAIL %s expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAIL %s expected %b actual %b", name, exp, act));
    end
  endtask

  // Called right after a rising edge, returns right after one
  task automatic axi_write(input logic [axi_addr_w-1:0] addr, input logic [xlen-1:0] data,
                           input logic [strb_w-1:0] strb, output axi_resp_e resp);
    logic [31:0] wait_cycles;
    s_awaddr  <= addr;
    s_awvalid <= 1'b1;
    s_wdata   <= data;
    s_wstrb   <= strb;
    s_wvalid  <= 1'b1;
    do begin
      @(posedge clk);
    end while (!s_awready);
    check_flag("wready with awready", 1'b1, s_wready);
    s_awvalid <= 1'b0;
    s_wvalid  <= 1'b0;
    do begin
      @(posedge clk);
    end while (!s_bvalid);
    resp = s_bresp;
    take_random_bits(2, wait_cycles);
    repeat (wait_cycles) @(posedge clk);  // Hold off bready
    s_bready <= 1'b1;
    @(posedge clk);
    s_bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [axi_addr_w-1:0] addr, output logic [xlen-1:0] data,
                          output axi_resp_e resp);
    logic [31:0] wait_cycles;
    s_araddr  <= addr;
    s_arvalid <= 1'b1;
    do begin
      @(posedge clk);
    end while (!s_arready);
    s_arvalid <= 1'b0;
    do begin
      @(posedge clk);
    end while (!s_rvalid);
    data = s_rdata;
    resp = s_rresp;
    take_random_bits(2, wait_cycles);
    repeat (wait_cycles) @(posedge clk);  // Hold off rready
    s_rready <= 1'b1;
    @(posedge clk);
    s_rready <= 1'b0;
  endtask

  // Reference core that decodes the word by its bit fields
  function automatic logic [xlen-1:0] model_exec(input logic [31:0] word);
    logic [3:0]      op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] res;
    logic            wb;
    op  = word[31:28];
    a   = model_regs[word[25:24]];
    b   = model_regs[word[23:22]];
    imm = {{(xlen - 24){word[23]}}, word[23:0]};
    res = '0;
    wb  = 1'b1;
    case (op)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_XOR:  res = a ^ b;
      OP_AND:  res = a & b;
      OP_ADDI: res = a + imm;
      OP_LI:   res = imm;
      default: wb = 1'b0;
    endcase
    if (wb) begin
      model_regs[word[27:26]] = res;
    end
    return res;
  endfunction

  task automatic issue_insn(input logic [31:0] word);
    axi_resp_e       resp;
    logic [xlen-1:0] data;
    logic [xlen-1:0] expected;
    expected = model_exec(word);
    axi_write(REG_INSN, word, 4'hF, resp);
    check_resp("insn write", OKAY, resp);
    axi_read(REG_RESULT, data, resp);
    check_resp("result read", OKAY, resp);
    check_data($sformatf("result of insn %h", word), expected, data);
  endtask

  task automatic run_insn(input logic [31:0] word, input logic exp_flag,
                          input logic [7:0] exp_count);
    axi_resp_e       resp;
    logic [xlen-1:0] data;
    issue_insn(word);
    axi_read(REG_STATUS, data, resp);
    check_resp("status read", OKAY, resp);
    check_data("status", {{(xlen - 16){1'b0}}, exp_count, 7'b0, exp_flag}, data);
    check_flag("corruption_detected port", exp_flag, corruption_detected);
  endtask

  task automatic run_stream(input int count, input bit cover_all, input logic exp_flag,
                            input logic [7:0] exp_count);
    logic [31:0] pick;
    logic [31:0] fields;
    logic [3:0]  op;
    for (int i = 0; i < count; i++) begin
      take_random_bits(3, pick);
      if (cover_all && i < 16) begin
        op = i[3:0];  // Every code once including no-ops
      end else if (pick < 6) begin
        op = pick[3:0];
      end else begin
        take_random_bits(4, pick);
        op = pick[3:0];
      end
      take_random_bits(28, fields);
      run_insn({op, fields[27:0]}, exp_flag, exp_count);
    end
  endtask

  initial begin : run_tests
    axi_resp_e       resp;
    logic [xlen-1:0] data;
    int              polls;
    rst_n      = 1'b0;
    s_awaddr   = '0;
    s_awvalid  = 1'b0;
    s_wdata    = '0;
    s_wstrb    = '0;
    s_wvalid   = 1'b0;
    s_bready   = 1'b0;
    s_araddr   = '0;
    s_arvalid  = 1'b0;
    s_rready   = 1'b0;
    lfsr_state = 32'h53ef;
    for (int r = 0; r < nregs; r++) begin
      model_regs[r] = '0;
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    run_stream(200, 1'b1, 1'b0, 8'd0);

    // Fault mask limited to byte 2 by the strobes
    axi_write(REG_INJECT, 32'hFFFF_FFFF, 4'b0100, resp);
    check_resp("inject write", OKAY, resp);
    axi_read(REG_INJECT, data, resp);
    check_resp("inject read", OKAY, resp);
    check_data("inject mask", 32'h00FF_0000, data);
    issue_insn({OP_LI, 2'd1, 2'd0, 24'h00_1234});
    polls = 0;
    data  = '0;
    while (!data[0]) begin
      if (polls == 16) begin
        stop_on_error("Corruption flag never rose after a fault was injected");
      end
      polls++;
      axi_read(REG_STATUS, data, resp);
      check_resp("status poll", OKAY, resp);
    end
    check_data("status after fault", {{(xlen - 16){1'b0}}, 8'd1, 7'b0, 1'b1}, data);
    check_flag("corruption_detected after fault", 1'b1, corruption_detected);
    axi_read(REG_INJECT, data, resp);
    check_resp("inject read after use", OKAY, resp);
    check_data("inject mask after use", '0, data);
    run_stream(5, 1'b0, 1'b1, 8'd1);

    axi_write(REG_CTRL, 32'h2, 4'h1, resp);  // Clear error
    check_resp("clear write", OKAY, resp);
    check_flag("corruption_detected after clear", 1'b0, corruption_detected);
    axi_read(REG_CTRL, data, resp);
    check_data("ctrl after clear", '0, data);
    run_stream(50, 1'b0, 1'b0, 8'd0);

    // Soft reset reaches the shadow after the delay
    axi_write(REG_CTRL, 32'h1, 4'h1, resp);
    check_resp("soft reset write", OKAY, resp);
    polls = 0;
    while (!shadow_reset) begin
      if (polls == 16) begin
        stop_on_error("shadow_reset never rose after a soft reset");
      end
      polls++;
      @(posedge clk);
    end
    axi_write(REG_CTRL, 32'h0, 4'h1, resp);
    check_resp("soft reset release", OKAY, resp);
    for (int r = 0; r < nregs; r++) begin
      model_regs[r] = '0;
    end
    for (int r = 0; r < nregs; r++) begin
      run_insn({OP_ADDI, r[1:0], r[1:0], 24'h0}, 1'b0, 8'd0);  // Reads back each reg
    end
    run_stream(20, 1'b0, 1'b0, 8'd0);

    axi_read(8'h14, data, resp);
    check_resp("unmapped read 0x14", SLVERR, resp);
    axi_read(8'h02, data, resp);
    check_resp("unaligned read 0x02", SLVERR, resp);
    axi_write(8'h20, 32'hDEAD_BEEF, 4'hF, resp);
    check_resp("unmapped write 0x20", SLVERR, resp);
    axi_write(8'hFC, 32'h1, 4'hF, resp);
    check_resp("unmapped write 0xFC", SLVERR, resp);
    axi_write(REG_STATUS, 32'hFFFF_FFFF, 4'hF, resp);
    check_resp("status write", OKAY, resp);
    axi_read(REG_STATUS, data, resp);
    check_resp("final status read", OKAY, resp);
    check_data("final status", '0, data);

    if (dut0.u_props.fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/lockstep_csr.sv
// ************************************************
// AXI4-Lite slave, one write and one read outstanding
// Address and write data must be valid together
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module lockstep_csr (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [lockstep_pkg::axi_addr_w-1:0] s_awaddr,
  input  logic                                s_awvalid,
  output logic                                s_awready,
  input  logic [lockstep_pkg::xlen-1:0]       s_wdata,
  input  logic [lockstep_pkg::strb_w-1:0]     s_wstrb,
  input  logic                                s_wvalid,
  output logic                                s_wready,
  output lockstep_pkg::axi_resp_e             s_bresp,
  output logic                                s_bvalid,
  input  logic                                s_bready,
  input  logic [lockstep_pkg::axi_addr_w-1:0] s_araddr,
  input  logic                                s_arvalid,
  output logic                                s_arready,
  output logic [lockstep_pkg::xlen-1:0]       s_rdata,
  output lockstep_pkg::axi_resp_e             s_rresp,
  output logic                                s_rvalid,
  input  logic                                s_rready,
  output logic                                insn_valid,
  output lockstep_pkg::lockstep_insn_u        insn,
  output logic                                soft_reset,
  output logic                                clear_error,
  output logic [lockstep_pkg::xlen-1:0]       inject_mask,
  input  logic                                main_trace_valid,
  input  logic [lockstep_pkg::xlen-1:0]       main_result,
  input  logic                                corruption,
  input  logic [7:0]                          mismatch_count
);
  import lockstep_pkg::*;

  logic            wr_start;
  logic            wr_fire;
  logic            wr_err;
  logic            rd_start;
  logic            rd_fire;
  logic            rd_err;
  logic [xlen-1:0] rd_data;
  logic [xlen-1:0] strb_mask;
  logic [xlen-1:0] status_word;
  logic [xlen-1:0] last_result;

  // Ready pulses for one cycle, then the response channel holds
  assign wr_start = s_awvalid && s_wvalid && !s_awready && !s_bvalid;
  assign wr_fire  = s_awvalid && s_wvalid && s_awready;
  assign rd_start = s_arvalid && !s_arready && !s_rvalid;
  assign rd_fire  = s_arvalid && s_arready;
  assign s_wready = s_awready;

  always_comb begin
    for (int b = 0; b < strb_w; b++) begin
      strb_mask[8*b +: 8] = {8{s_wstrb[b]}};
    end
  end

  always_comb begin
    case (s_awaddr)
      REG_CTRL, REG_INSN, REG_INJECT, REG_STATUS, REG_RESULT: wr_err = 1'b0;
      default: wr_err = 1'b1;
    endcase
  end

  assign status_word = {{(xlen - 16){1'b0}}, mismatch_count, 7'b0, corruption};

  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    case (s_araddr)
      REG_CTRL:   rd_data = {{(xlen - 1){1'b0}}, soft_reset};
      REG_INSN:   rd_data = insn;
      REG_INJECT: rd_data = inject_mask;
      REG_STATUS: rd_data = status_word;
      REG_RESULT: rd_data = last_result;
      default:    rd_err  = 1'b1;
    endcase
  end

  // Write channel handshake
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s_awready <= 1'b0;
      s_bvalid  <= 1'b0;
      s_bresp   <= OKAY;
    end else begin
      s_awready <= wr_start;
      if (wr_fire) begin
        s_bvalid <= 1'b1;
        s_bresp  <= wr_err ? SLVERR : OKAY;
      end else if (s_bready) begin
        s_bvalid <= 1'b0;
      end
    end
  end

  // Read channel handshake
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s_arready <= 1'b0;
      s_rvalid  <= 1'b0;
      s_rresp   <= OKAY;
    end else begin
      s_arready <= rd_start;
      if (rd_fire) begin
        s_rvalid <= 1'b1;
        s_rresp  <= rd_err ? SLVERR : OKAY;
      end else if (s_rready) begin
        s_rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      s_rdata <= rd_data;
    end
  end

  // Register updates
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      soft_reset  <= 1'b0;
      clear_error <= 1'b0;
      insn_valid  <= 1'b0;
      insn        <= '0;
      inject_mask <= '0;
      last_result <= '0;
    end else begin
      clear_error <= 1'b0;
      insn_valid  <= 1'b0;
      if (main_trace_valid) begin
        last_result <= main_result;
        inject_mask <= '0;  // Fault is one-shot
      end
      if (wr_fire) begin
        case (s_awaddr)
          REG_CTRL: begin
            if (s_wstrb[0]) begin
              soft_reset  <= s_wdata[CTRL_SOFT_RESET];
              clear_error <= s_wdata[CTRL_CLEAR_ERR];
            end
          end
          REG_INSN: begin
            insn       <= s_wdata;  // Strobes ignored
            insn_valid <= 1'b1;
          end
          REG_INJECT: begin
            inject_mask <= (inject_mask & ~strb_mask) | (s_wdata & strb_mask);
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/lockstep_delay.sv
// ************************************************
// Fixed latency of LOCKSTEP_DELAY cycles, 1 to 8
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module lockstep_delay #(
  parameter int LOCKSTEP_DELAY = lockstep_pkg::LOCKSTEP_DELAY_DEFAULT,
  parameter int WIDTH          = 1
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  logic [WIDTH-1:0] in_data,
  output logic             out_valid,
  output logic [WIDTH-1:0] out_data
);

  logic             valid_q [LOCKSTEP_DELAY];
  logic [WIDTH-1:0] data_q  [LOCKSTEP_DELAY];

  if (LOCKSTEP_DELAY < 1 || LOCKSTEP_DELAY > 8) begin : g_bad_delay
    $error("LOCKSTEP_DELAY must be in 1..8");
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < LOCKSTEP_DELAY; i++) begin
        valid_q[i] <= 1'b0;
        data_q[i]  <= '0;
      end
    end else begin
      valid_q[0] <= in_valid;
      data_q[0]  <= in_data;
      for (int i = 1; i < LOCKSTEP_DELAY; i++) begin
        valid_q[i] <= valid_q[i-1];
        data_q[i]  <= data_q[i-1];
      end
    end
  end

  assign out_valid = valid_q[LOCKSTEP_DELAY-1];
  assign out_data  = data_q[LOCKSTEP_DELAY-1];

endmodule

`default_nettype wire

// File: verilog/lockstep_pkg.sv
// ************************************************
// Instruction layout is fixed at 32 bits, so xlen must stay 32
// Only the opcodes listed here write back, all others trace as no-ops
// ************************************************
`default_nettype none

package lockstep_pkg;

  localparam int xlen       = 32;
  localparam int imm_w      = 24;
  localparam int nregs      = 4;
  localparam int axi_addr_w = 8;
  localparam int strb_w     = xlen / 8;

  // Shadow core lag in cycles, valid range 1 to 8
  localparam int LOCKSTEP_DELAY_DEFAULT = 2;

  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_XOR  = 4'h2,
    OP_AND  = 4'h3,
    OP_ADDI = 4'h4,
    OP_LI   = 4'h5
  } lockstep_op_e;

  // Register-register view
  typedef struct packed {
    lockstep_op_e op;
    logic [1:0]   rd;
    logic [1:0]   rs1;
    logic [1:0]   rs2;
    logic [21:0]  rsvd;
  } lockstep_rtype_s;

  // Immediate view, imm is sign-extended to xlen
  typedef struct packed {
    lockstep_op_e             op;
    logic [1:0]               rd;
    logic [1:0]               rs1;
    logic signed [imm_w-1:0]  imm;
  } lockstep_itype_s;

  typedef union packed {
    lockstep_rtype_s rtype;
    lockstep_itype_s itype;
  } lockstep_insn_u;

  // Register map, byte addresses
  localparam logic [axi_addr_w-1:0] REG_CTRL   = 8'h00;
  localparam logic [axi_addr_w-1:0] REG_INSN   = 8'h04;
  localparam logic [axi_addr_w-1:0] REG_INJECT = 8'h08;
  localparam logic [axi_addr_w-1:0] REG_STATUS = 8'h0C;
  localparam logic [axi_addr_w-1:0] REG_RESULT = 8'h10;

  localparam int CTRL_SOFT_RESET = 0;
  localparam int CTRL_CLEAR_ERR  = 1;  // Self-clearing

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

endpackage

`default_nettype wire

// File: verilog/lockstep_top.sv
// ************************************************
// Shadow core runs LOCKSTEP_DELAY cycles behind the main core
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module lockstep_top #(
  parameter int LOCKSTEP_DELAY = lockstep_pkg::LOCKSTEP_DELAY_DEFAULT
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [lockstep_pkg::axi_addr_w-1:0] s_awaddr,
  input  logic                                s_awvalid,
  output logic                                s_awready,
  input  logic [lockstep_pkg::xlen-1:0]       s_wdata,
  input  logic [lockstep_pkg::strb_w-1:0]     s_wstrb,
  input  logic                                s_wvalid,
  output logic                                s_wready,
  output lockstep_pkg::axi_resp_e             s_bresp,
  output logic                                s_bvalid,
  input  logic                                s_bready,
  input  logic [lockstep_pkg::axi_addr_w-1:0] s_araddr,
  input  logic                                s_arvalid,
  output logic                                s_arready,
  output logic [lockstep_pkg::xlen-1:0]       s_rdata,
  output lockstep_pkg::axi_resp_e             s_rresp,
  output logic                                s_rvalid,
  input  logic                                s_rready,
  output logic                                shadow_reset,
  output logic                                corruption_detected
);
  import lockstep_pkg::*;

  localparam int in_w    = 1 + xlen;  // Soft reset and instruction
  localparam int trace_w = 2 + xlen;  // rd and result

  logic             insn_valid;
  lockstep_insn_u   insn;
  logic             soft_reset;
  logic             clear_error;
  logic [xlen-1:0]  inject_mask;
  logic             main_trace_valid;
  logic [1:0]       main_trace_rd;
  logic [xlen-1:0]  main_trace_result;
  logic [xlen-1:0]  main_result_inj;
  logic             shadow_insn_valid;
  logic [in_w-1:0]  shadow_in_data;
  lockstep_insn_u   shadow_insn;
  logic             shadow_trace_valid;
  logic [1:0]       shadow_trace_rd;
  logic [xlen-1:0]  shadow_trace_result;
  logic             dly_trace_valid;
  logic [trace_w-1:0] dly_trace_data;
  logic [7:0]       mismatch_count;

  // Fault injection on the main trace only
  assign main_result_inj = main_trace_result ^ inject_mask;

  assign shadow_reset = shadow_in_data[in_w-1];
  assign shadow_insn  = shadow_in_data[xlen-1:0];

  lockstep_csr u_csr (
    .clk, .rst_n,
    .s_awaddr, .s_awvalid, .s_awready,
    .s_wdata, .s_wstrb, .s_wvalid, .s_wready,
    .s_bresp, .s_bvalid, .s_bready,
    .s_araddr, .s_arvalid, .s_arready,
    .s_rdata, .s_rresp, .s_rvalid, .s_rready,
    .insn_valid, .insn, .soft_reset, .clear_error, .inject_mask,
    .main_trace_valid,
    .main_result    (main_trace_result),
    .corruption     (corruption_detected),
    .mismatch_count
  );

  mini_core core_main (
    .clk, .rst_n, .soft_reset, .insn_valid, .insn,
    .trace_valid  (main_trace_valid),
    .trace_rd     (main_trace_rd),
    .trace_result (main_trace_result)
  );

  lockstep_delay #(.LOCKSTEP_DELAY(LOCKSTEP_DELAY), .WIDTH(in_w)) delay_in (
    .clk, .rst_n,
    .in_valid  (insn_valid),
    .in_data   ({soft_reset, insn}),
    .out_valid (shadow_insn_valid),
    .out_data  (shadow_in_data)
  );

  mini_core core_shadow (
    .clk, .rst_n,
    .soft_reset   (shadow_reset),
    .insn_valid   (shadow_insn_valid),
    .insn         (shadow_insn),
    .trace_valid  (shadow_trace_valid),
    .trace_rd     (shadow_trace_rd),
    .trace_result (shadow_trace_result)
  );

  lockstep_delay #(.LOCKSTEP_DELAY(LOCKSTEP_DELAY), .WIDTH(trace_w)) delay_trace (
    .clk, .rst_n,
    .in_valid  (main_trace_valid),
    .in_data   ({main_trace_rd, main_result_inj}),
    .out_valid (dly_trace_valid),
    .out_data  (dly_trace_data)
  );

  trace_checker u_checker (
    .clk, .rst_n, .clear_error,
    .main_valid    (dly_trace_valid),
    .main_rd       (dly_trace_data[trace_w-1 -: 2]),
    .main_result   (dly_trace_data[xlen-1:0]),
    .shadow_valid  (shadow_trace_valid),
    .shadow_rd     (shadow_trace_rd),
    .shadow_result (shadow_trace_result),
    .corruption_detected,
    .mismatch_count
  );

endmodule

`default_nettype wire

// File: verilog/mini_core.sv
// ************************************************
// One instruction per insn_valid, no stalls and no hazards
// soft_reset wins over a valid instruction in the same cycle
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module mini_core (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          soft_reset,
  input  logic                          insn_valid,
  input  lockstep_pkg::lockstep_insn_u  insn,
  output logic                          trace_valid,
  output logic [1:0]                    trace_rd,
  output logic [lockstep_pkg::xlen-1:0] trace_result
);
  import lockstep_pkg::*;

  logic [xlen-1:0] regs [nregs];
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] imm_ext;
  logic [xlen-1:0] result;
  logic            wb_en;

  // Both views share op, rd and rs1
  assign op_a = regs[insn.rtype.rs1];
  assign op_b = regs[insn.rtype.rs2];

  assign imm_ext = {{(xlen - imm_w){insn.itype.imm[imm_w-1]}}, insn.itype.imm};

  // Execute stage
  always_comb begin
    result = '0;
    wb_en  = 1'b1;
    case (insn.rtype.op)
      OP_ADD: begin
        result = op_a + op_b;
      end
      OP_SUB: begin
        result = op_a - op_b;
      end
      OP_XOR: begin
        result = op_a ^ op_b;
      end
      OP_AND: begin
        result = op_a & op_b;
      end
      OP_ADDI: begin
        result = op_a + imm_ext;
      end
      OP_LI: begin
        result = imm_ext;  // rs1 ignored
      end
      default: begin
        wb_en = 1'b0;      // No-op, result stays zero
      end
    endcase
  end

  // Architectural state and trace strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < nregs; i++) begin
        regs[i] <= '0;
      end
      trace_valid <= 1'b0;
    end else if (soft_reset) begin
      for (int i = 0; i < nregs; i++) begin
        regs[i] <= '0;
      end
      trace_valid <= 1'b0;
    end else begin
      trace_valid <= insn_valid;
      if (insn_valid && wb_en) begin
        regs[insn.rtype.rd] <= result;
      end
    end
  end

  // Trace payload, qualified by trace_valid
  always_ff @(posedge clk) begin
    if (insn_valid) begin
      trace_rd     <= insn.rtype.rd;
      trace_result <= result;
    end
  end

endmodule

`default_nettype wire

// File: verilog/trace_checker.sv
// ************************************************
// Inputs must already be aligned cycle by cycle
// clear_error wins over a mismatch in the same cycle
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module trace_checker (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          clear_error,
  input  logic                          main_valid,
  input  logic [1:0]                    main_rd,
  input  logic [lockstep_pkg::xlen-1:0] main_result,
  input  logic                          shadow_valid,
  input  logic [1:0]                    shadow_rd,
  input  logic [lockstep_pkg::xlen-1:0] shadow_result,
  output logic                          corruption_detected,
  output logic [7:0]                    mismatch_count
);

  logic mismatch;
  logic payload_diff;

  // Payload only matters when both sides traced
  assign payload_diff = (main_rd != shadow_rd) || (main_result != shadow_result);
  assign mismatch     = (main_valid != shadow_valid) ||
                        (main_valid && shadow_valid && payload_diff);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      corruption_detected <= 1'b0;
      mismatch_count      <= '0;
    end else if (clear_error) begin
      corruption_detected <= 1'b0;
      mismatch_count      <= '0;
    end else if (mismatch) begin
      corruption_detected <= 1'b1;  // Sticky
      if (mismatch_count != 8'hFF) begin
        mismatch_count <= mismatch_count + 8'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
verilog/lockstep_pkg.sv
verilog/lockstep_delay.sv
verilog/mini_core.sv
verilog/trace_checker.sv
verilog/lockstep_csr.sv
verilog/lockstep_top.sv
testbench/lockstep_properties.sv
testbench/lockstep_tb.sv
